// ==== verilog/videoPkg.sv ====
// Palette video shared definitions

package videoPkg;

	// ============================================================
	// Palette geometry
	// ============================================================

	// Index width inside one bank
	localparam int PalAddrWidth = 12;

	// Banks selected by the system latch
	localparam int PalBankCount = 2;

	// Bank bit followed by the index
	localparam int RamAddrWidth = PalAddrWidth + $clog2(PalBankCount);

	// Master clocks per pixel
	localparam int DefaultPixelDivide = 8;

	// ============================================================
	// Data types
	// ============================================================

	// One palette entry, dark bit on top
	typedef struct packed {
		logic       dark;
		logic       lowRed;
		logic       lowGreen;
		logic       lowBlue;
		logic [3:0] redNib;
		logic [3:0] greenNib;
		logic [3:0] blueNib;
	} colorWordT;

	typedef logic [7:0] channelT;
	typedef logic [PalAddrWidth-1:0] palAddrT;
	typedef logic [RamAddrWidth-1:0] ramAddrT;

	// System latch select; unlisted codes are ignored
	typedef logic [2:0] latchSelT;
	localparam latchSelT LatchShadow  = 3'd0;
	localparam latchSelT LatchPalBank = 3'd1;

endpackage

// ==== verilog/pixelClockGen.sv ====
// Pixel clock enable generator

module pixelClockGen import videoPkg::*; #(
	parameter int PixelDivide = DefaultPixelDivide
) (
	input  logic CLK_48M,
	input  logic nRESET,
	output logic pixelCe
);

	localparam int CountWidth = (PixelDivide > 1) ? $clog2(PixelDivide) : 1;
	localparam logic [CountWidth-1:0] LastCount = CountWidth'(PixelDivide - 1);

	logic [CountWidth-1:0] count;

	// Counter wraps at PixelDivide, pulse on the wrap
	always_ff @(posedge CLK_48M) begin
		if (!nRESET) begin
			count   <= '0;
			pixelCe <= 1'b0;
		end else begin
			if (count == LastCount) begin
				count   <= '0;
				pixelCe <= 1'b1;
			end else begin
				count   <= count + 1'b1;
				pixelCe <= 1'b0;
			end
		end
	end

	// ============================================================
	// Checks
	// ============================================================

	// Pulses stay a full pixel apart
	pulseSpacing: assert property (
		@(posedge CLK_48M) disable iff (!nRESET)
		pixelCe |=> !pixelCe [*(PixelDivide - 1)]
	) else $error("pixelCe pulses closer than %0d cycles", PixelDivide);

endmodule

// ==== verilog/systemLatch.sv ====
// System latch and palette write port

module systemLatch import videoPkg::*; (
	input  logic      CLK_48M,
	input  logic      nRESET,

	// Control strobe
	input  logic      ctrlWrite,
	input  latchSelT  ctrlSel,
	input  logic      ctrlValue,

	// CPU palette write
	input  logic      palWrite,
	input  palAddrT   palAddr,
	input  colorWordT palData,

	output logic      shadow,
	output logic      palBank,
	output logic      ramWrite,
	output ramAddrT   ramWriteAddr,
	output colorWordT ramWriteData
);

	// ============================================================
	// Control latches
	// ============================================================

	always_ff @(posedge CLK_48M) begin
		if (!nRESET) begin
			shadow  <= 1'b0;
			palBank <= 1'b0;
		end else if (ctrlWrite) begin
			case (ctrlSel)
				LatchShadow:  shadow  <= ctrlValue;
				LatchPalBank: palBank <= ctrlValue;
				default: ;
			endcase
		end
	end

	// ============================================================
	// Palette write register
	// ============================================================

	always_ff @(posedge CLK_48M) begin
		if (!nRESET) begin
			ramWrite <= 1'b0;
		end else begin
			ramWrite <= palWrite;
		end
	end

	// Bank is sampled before any same-cycle bank change lands
	always_ff @(posedge CLK_48M) begin
		if (palWrite) begin
			ramWriteAddr <= {palBank, palAddr};
			ramWriteData <= palData;
		end
	end

	// ============================================================
	// Checks
	// ============================================================

	ctrlSelKnown: assert property (
		@(posedge CLK_48M) disable iff (!nRESET)
		ctrlWrite |-> !$isunknown(ctrlSel)
	) else $error("ctrlSel unknown during ctrlWrite");

endmodule

// ==== verilog/paletteRam.sv ====
// Banked palette memory

module paletteRam import videoPkg::*; (
	input  logic      CLK_48M,
	input  logic      pixelCe,

	// Write side from the system latch
	input  logic      ramWrite,
	input  ramAddrT   ramWriteAddr,
	input  colorWordT ramWriteData,

	// Pixel read side
	input  logic      palBank,
	input  palAddrT   pixelIndex,
	output colorWordT colorWord
);

	localparam int Depth = PalBankCount << PalAddrWidth;

	colorWordT mem [Depth];

	ramAddrT readAddr;

	// Renderer reads from the bank currently latched
	assign readAddr = {palBank, pixelIndex};

	// ============================================================
	// Write port
	// ============================================================

	always_ff @(posedge CLK_48M) begin
		if (ramWrite) begin
			mem[ramWriteAddr] <= ramWriteData;
		end
	end

	// ============================================================
	// Read port
	// ============================================================

	// Registered once per pixel; same-edge write is not seen
	always_ff @(posedge CLK_48M) begin
		if (pixelCe) begin
			colorWord <= mem[readAddr];
		end
	end

endmodule

// ==== verilog/colorDecode.sv ====
// Colour word to RGB888 decode

module colorDecode import videoPkg::*; (
	input  logic      CLK_48M,
	input  logic      nRESET,
	input  logic      pixelCe,
	input  colorWordT colorWord,
	output channelT   red,
	output channelT   green,
	output channelT   blue
);

	// ============================================================
	// Channel decode
	// ============================================================

	// Six bits are nibble, low bit, nibble MSB; dark subtracts one
	function automatic channelT decodeChannel(
		input logic [3:0] nib,
		input logic       lowBit,
		input logic       dark
	);
		logic [6:0] level;
		level = {1'b0, nib, lowBit, nib[3]} - {6'd0, dark};
		// Underflow only from an all-zero level with dark set
		if (level[6]) begin
			return '0;
		end
		return {level[5:0], level[4:3]};
	endfunction

	channelT redNext;
	channelT greenNext;
	channelT blueNext;

	assign redNext   = decodeChannel(colorWord.redNib, colorWord.lowRed, colorWord.dark);
	assign greenNext = decodeChannel(colorWord.greenNib, colorWord.lowGreen, colorWord.dark);
	assign blueNext  = decodeChannel(colorWord.blueNib, colorWord.lowBlue, colorWord.dark);

	// ============================================================
	// Pixel register
	// ============================================================

	always_ff @(posedge CLK_48M) begin
		if (!nRESET) begin
			red   <= '0;
			green <= '0;
			blue  <= '0;
		end else if (pixelCe) begin
			red   <= redNext;
			green <= greenNext;
			blue  <= blueNext;
		end
	end

endmodule

// ==== verilog/pixelOutput.sv ====
// Output stage with shadow, enable and blank delay

module pixelOutput import videoPkg::*; (
	input  logic    CLK_48M,
	input  logic    nRESET,
	input  logic    pixelCe,

	input  channelT red,
	input  channelT green,
	input  channelT blue,
	input  logic    shadow,
	input  logic    videoEnable,
	input  logic    hBlankIn,
	input  logic    vBlankIn,

	output channelT redOut,
	output channelT greenOut,
	output channelT blueOut,
	output logic    hBlank,
	output logic    vBlank
);

	// Blank levels, first two stages
	logic [1:0] hBlankPipe;
	logic [1:0] vBlankPipe;

	// Black when disabled, half brightness under shadow
	function automatic channelT shadeChannel(
		input channelT level,
		input logic    shadowOn,
		input logic    enable
	);
		if (!enable) begin
			return '0;
		end
		return shadowOn ? (level >> 1) : level;
	endfunction

	// ============================================================
	// Colour register
	// ============================================================

	always_ff @(posedge CLK_48M) begin
		if (!nRESET) begin
			redOut   <= '0;
			greenOut <= '0;
			blueOut  <= '0;
		end else if (pixelCe) begin
			redOut   <= shadeChannel(red, shadow, videoEnable);
			greenOut <= shadeChannel(green, shadow, videoEnable);
			blueOut  <= shadeChannel(blue, shadow, videoEnable);
		end
	end

	// ============================================================
	// Blank alignment
	// ============================================================

	// Three pixels deep to match RAM, decode and output stages
	always_ff @(posedge CLK_48M) begin
		if (!nRESET) begin
			hBlankPipe <= '0;
			vBlankPipe <= '0;
			hBlank     <= 1'b0;
			vBlank     <= 1'b0;
		end else if (pixelCe) begin
			hBlankPipe <= {hBlankPipe[0], hBlankIn};
			vBlankPipe <= {vBlankPipe[0], vBlankIn};
			hBlank     <= hBlankPipe[1];
			vBlank     <= vBlankPipe[1];
		end
	end

endmodule

// ==== verilog/paletteVideoTop.sv ====
// Palette video output path

module paletteVideoTop import videoPkg::*; #(
	parameter int PixelDivide = DefaultPixelDivide
) (
	input  logic      CLK_48M,
	input  logic      nRESET,

	// CPU side
	input  logic      palWrite,
	input  palAddrT   palAddr,
	input  colorWordT palData,
	input  logic      ctrlWrite,
	input  latchSelT  ctrlSel,
	input  logic      ctrlValue,

	// Renderer side
	input  palAddrT   pixelIndex,
	input  logic      hBlankIn,
	input  logic      vBlankIn,
	input  logic      videoEnable,

	// Video out
	output channelT   redOut,
	output channelT   greenOut,
	output channelT   blueOut,
	output logic      hBlank,
	output logic      vBlank,
	output logic      pixelCe
);

	logic      shadow;
	logic      palBank;
	logic      ramWrite;
	ramAddrT   ramWriteAddr;
	colorWordT ramWriteData;
	colorWordT colorWord;
	channelT   red;
	channelT   green;
	channelT   blue;

	// ============================================================
	// Pixel enable
	// ============================================================

	pixelClockGen #(
		.PixelDivide(PixelDivide)
	) clockGen (
		.CLK_48M(CLK_48M),
		.nRESET (nRESET),
		.pixelCe(pixelCe)
	);

	// ============================================================
	// CPU side
	// ============================================================

	systemLatch latch (
		.CLK_48M     (CLK_48M),
		.nRESET      (nRESET),
		.ctrlWrite   (ctrlWrite),
		.ctrlSel     (ctrlSel),
		.ctrlValue   (ctrlValue),
		.palWrite    (palWrite),
		.palAddr     (palAddr),
		.palData     (palData),
		.shadow      (shadow),
		.palBank     (palBank),
		.ramWrite    (ramWrite),
		.ramWriteAddr(ramWriteAddr),
		.ramWriteData(ramWriteData)
	);

	// ============================================================
	// Colour pipeline
	// ============================================================

	paletteRam palRam (
		.CLK_48M     (CLK_48M),
		.pixelCe     (pixelCe),
		.ramWrite    (ramWrite),
		.ramWriteAddr(ramWriteAddr),
		.ramWriteData(ramWriteData),
		.palBank     (palBank),
		.pixelIndex  (pixelIndex),
		.colorWord   (colorWord)
	);

	colorDecode decode (
		.CLK_48M  (CLK_48M),
		.nRESET   (nRESET),
		.pixelCe  (pixelCe),
		.colorWord(colorWord),
		.red      (red),
		.green    (green),
		.blue     (blue)
	);

	pixelOutput outStage (
		.CLK_48M    (CLK_48M),
		.nRESET     (nRESET),
		.pixelCe    (pixelCe),
		.red        (red),
		.green      (green),
		.blue       (blue),
		.shadow     (shadow),
		.videoEnable(videoEnable),
		.hBlankIn   (hBlankIn),
		.vBlankIn   (vBlankIn),
		.redOut     (redOut),
		.greenOut   (greenOut),
		.blueOut    (blueOut),
		.hBlank     (hBlank),
		.vBlank     (vBlank)
	);

endmodule

// ==== tb/colorRef.svh ====
// Palette colour reference model

`ifndef COLOR_REF_SVH
`define COLOR_REF_SVH

	// Model copy of both palette banks
	logic [15:0] refMem [PalBankCount][1 << PalAddrWidth];
	bit          refWritten [PalBankCount][1 << PalAddrWidth];

	// Record a CPU write in the model banks
	function automatic void refStore(input logic bank, input palAddrT addr,
			input logic [15:0] word);
		refMem[bank][addr]     = word;
		refWritten[bank][addr] = 1'b1;
	endfunction

	// Channel 0 is red, 1 green, 2 blue
	function automatic logic [7:0] decodeRef(input logic [15:0] word, input int channel);
		int nib;
		int low;
		int level;
		nib   = int'((word >> (8 - 4 * channel)) & 16'h000F);
		low   = int'(word[14 - channel]);
		// Nibble, then low bit, then nibble MSB
		level = nib * 4 + low * 2 + nib / 8;
		if (word[15]) begin
			level = level - 1;
		end
		if (level < 0) begin
			level = 0;
		end
		// Bits 4 and 3 of the six repeated below
		return 8'(level * 4 + (level / 8) % 4);
	endfunction

	// Output stage rule
	function automatic logic [7:0] shadeRef(input logic [7:0] level, input logic shadowOn,
			input logic enableOn);
		if (!enableOn) begin
			return 8'd0;
		end
		if (shadowOn) begin
			return level / 2;
		end
		return level;
	endfunction

`endif

// ==== tb/paletteVideoTb.sv ====
// Palette video testbench

module paletteVideoTb import videoPkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int PixelDivide = DefaultPixelDivide;
	localparam int ClockPeriod = 100;
	localparam int DriveDelay = 10;
	localparam logic [31:0] Seed = 32'h4f1a;

	// Pixels per phase
	localparam int EdgeCount = 5;
	localparam int LoadCount = 48;
	localparam int DecodeCount = 64;
	localparam int BankCount = 48;
	localparam int ShadowCount = 64;
	localparam int DisableCount = 32;
	localparam int BlankCount = 64;
	localparam int TotalPixels = 4 + 2 * LoadCount + EdgeCount + DecodeCount + 3 * BankCount
		+ ShadowCount + DisableCount + BlankCount + 8 + 3;
	localparam int TimeoutNs = (TotalPixels + 20) * PixelDivide * ClockPeriod;

	localparam logic [15:0] EdgeWords [EdgeCount] =
		'{16'h8000, 16'hF000, 16'h0000, 16'h7FFF, 16'hFFFF};

	logic      CLK_48M;
	logic      nRESET;
	logic      palWrite;
	palAddrT   palAddr;
	colorWordT palData;
	logic      ctrlWrite;
	latchSelT  ctrlSel;
	logic      ctrlValue;
	palAddrT   pixelIndex;
	logic      hBlankIn;
	logic      vBlankIn;
	logic      videoEnable;
	channelT   redOut;
	channelT   greenOut;
	channelT   blueOut;
	logic      hBlank;
	logic      vBlank;
	logic      pixelCe;

	// One sampled pixel on its way to the outputs
	typedef struct packed {
		logic [15:0] word;
		logic        known;
		logic        hBlank;
		logic        vBlank;
		logic        shadowOn;
		logic        enableOn;
	} pixelT;

	pixelT   pending[$];
	palAddrT loadAddr[$];
	logic    refBank;
	logic    refShadow;
	logic    curEnable;
	string   testName;

	`include "colorRef.svh"

	paletteVideoTop #(
		.PixelDivide(PixelDivide)
	) dut (
		.CLK_48M    (CLK_48M),
		.nRESET     (nRESET),
		.palWrite   (palWrite),
		.palAddr    (palAddr),
		.palData    (palData),
		.ctrlWrite  (ctrlWrite),
		.ctrlSel    (ctrlSel),
		.ctrlValue  (ctrlValue),
		.pixelIndex (pixelIndex),
		.hBlankIn   (hBlankIn),
		.vBlankIn   (vBlankIn),
		.videoEnable(videoEnable),
		.redOut     (redOut),
		.greenOut   (greenOut),
		.blueOut    (blueOut),
		.hBlank     (hBlank),
		.vBlank     (vBlank),
		.pixelCe    (pixelCe)
	);

	initial begin
		CLK_48M = 1'b0;
		forever begin
			#(ClockPeriod / 2) CLK_48M = ~CLK_48M;
		end
	end

	initial begin
		#(TimeoutNs);
		$display("sim failed");
		$fatal(1, "simulation timed out after %0d ns", TimeoutNs);
	end

	// ============================================================
	// Checking
	// ============================================================

	task automatic checkValue(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("** Error %s: expected %0h, actual %0h", name, expected, actual);
			$display("sim failed");
			$fatal(1, "mismatch in %s", name);
		end
	endtask

	task automatic checkQuiet();
		checkValue({testName, " red"}, 32'd0, 32'(redOut));
		checkValue({testName, " green"}, 32'd0, 32'(greenOut));
		checkValue({testName, " blue"}, 32'd0, 32'(blueOut));
		checkValue({testName, " hBlank"}, 32'd0, 32'(hBlank));
		checkValue({testName, " vBlank"}, 32'd0, 32'(vBlank));
	endtask

	// Unwritten entries are only checked while video is off
	task automatic checkPixel(input pixelT p);
		if (!p.enableOn || p.known) begin
			checkValue({testName, " red"},
				32'(shadeRef(decodeRef(p.word, 0), p.shadowOn, p.enableOn)), 32'(redOut));
			checkValue({testName, " green"},
				32'(shadeRef(decodeRef(p.word, 1), p.shadowOn, p.enableOn)), 32'(greenOut));
			checkValue({testName, " blue"},
				32'(shadeRef(decodeRef(p.word, 2), p.shadowOn, p.enableOn)), 32'(blueOut));
		end
		checkValue({testName, " hBlank"}, 32'(p.hBlank), 32'(hBlank));
		checkValue({testName, " vBlank"}, 32'(p.vBlank), 32'(vBlank));
	endtask

	// ============================================================
	// Pixel steps
	// ============================================================

	// Returns in the cycle where pixelCe is high
	task automatic waitPixelCe();
		do begin
			@(posedge CLK_48M);
			#(DriveDelay);
		end while (!pixelCe);
	endtask

	// Outputs now reflect the pixel sampled three enables back
	task automatic startPixel(input palAddrT idx);
		pixelT oldest;
		pixelT entry;
		waitPixelCe();
		if (pending.size() == 3) begin
			oldest = pending.pop_front();
			checkPixel(oldest);
		end
		pixelIndex     = idx;
		hBlankIn       = 1'($urandom());
		vBlankIn       = 1'($urandom());
		videoEnable    = curEnable;
		entry.word     = refMem[refBank][idx];
		entry.known    = refWritten[refBank][idx];
		entry.hBlank   = hBlankIn;
		entry.vBlank   = vBlankIn;
		entry.shadowOn = 1'b0;
		entry.enableOn = 1'b0;
		pending.push_back(entry);
		// Oldest pixel passes the output stage on this enable
		if (pending.size() == 3) begin
			oldest          = pending[0];
			oldest.shadowOn = refShadow;
			oldest.enableOn = curEnable;
			pending[0]      = oldest;
		end
	endtask

	task automatic finishPixel();
		@(posedge CLK_48M);
		#(DriveDelay);
		palWrite  = 1'b0;
		ctrlWrite = 1'b0;
	endtask

	function automatic palAddrT pickIndex();
		if (loadAddr.size() == 0) begin
			return '0;
		end
		return loadAddr[$urandom_range(0, loadAddr.size() - 1)];
	endfunction

	task automatic showPixels(input int count);
		for (int i = 0; i < count; i++) begin
			startPixel(pickIndex());
			finishPixel();
		end
	endtask

	task automatic writePalette(input palAddrT addr, input logic [15:0] word);
		startPixel(pickIndex());
		palWrite = 1'b1;
		palAddr  = addr;
		palData  = colorWordT'(word);
		refStore(refBank, addr, word);
		finishPixel();
	endtask

	task automatic writeLatch(input latchSelT sel, input logic value);
		startPixel(pickIndex());
		ctrlWrite = 1'b1;
		ctrlSel   = sel;
		ctrlValue = value;
		if (sel == LatchShadow) begin
			refShadow = value;
		end else if (sel == LatchPalBank) begin
			refBank = value;
		end
		finishPixel();
	endtask

	// ============================================================
	// Tests
	// ============================================================

	task automatic checkReset();
		int cycle;
		int lastPulse;
		int pulses;
		testName = "reset";
		repeat (3) @(posedge CLK_48M);
		#(DriveDelay);
		checkQuiet();
		checkValue("reset pixelCe", 32'd0, 32'(pixelCe));
		nRESET    = 1'b1;
		cycle     = 0;
		lastPulse = 0;
		pulses    = 0;
		while (pulses < 3) begin
			@(posedge CLK_48M);
			#(DriveDelay);
			cycle++;
			if (pulses == 0) begin
				checkQuiet();
			end
			if (pixelCe) begin
				checkValue("pixelCe spacing", 32'(PixelDivide), 32'(cycle - lastPulse));
				lastPulse = cycle;
				pulses++;
			end
		end
	endtask

	task automatic checkDecode();
		palAddrT     addr;
		logic [15:0] word;
		testName  = "palette decode";
		curEnable = 1'b1;
		for (int i = 0; i < LoadCount; i++) begin
			do begin
				addr = PalAddrWidth'($urandom());
			end while (refWritten[0][addr]);
			if (i < EdgeCount) begin
				word = EdgeWords[i];
			end else begin
				word = 16'($urandom());
			end
			loadAddr.push_back(addr);
			writePalette(addr, word);
		end
		// Dark and zero-nibble words are always shown once
		for (int i = 0; i < EdgeCount; i++) begin
			startPixel(loadAddr[i]);
			finishPixel();
		end
		showPixels(DecodeCount);
	endtask

	task automatic checkBanks();
		logic [15:0] word;
		testName = "bank select";
		writeLatch(LatchPalBank, 1'b1);
		foreach (loadAddr[i]) begin
			word = 16'($urandom());
			if (word == refMem[0][loadAddr[i]]) begin
				word = ~word;
			end
			writePalette(loadAddr[i], word);
		end
		showPixels(BankCount);
		writeLatch(LatchPalBank, 1'b0);
		showPixels(BankCount);
		writeLatch(LatchPalBank, 1'b1);
		showPixels(BankCount);
		writeLatch(LatchPalBank, 1'b0);
	endtask

	task automatic checkShadow();
		testName = "shadow";
		// Unused select code must leave both latches alone
		writeLatch(3'd5, 1'b1);
		writeLatch(LatchShadow, 1'b1);
		showPixels(ShadowCount);
		writeLatch(LatchShadow, 1'b0);
	endtask

	task automatic checkDisable();
		testName  = "video enable";
		curEnable = 1'b0;
		for (int i = 0; i < DisableCount; i++) begin
			startPixel(PalAddrWidth'($urandom()));
			finishPixel();
		end
		curEnable = 1'b1;
	endtask

	initial begin
		nRESET      = 1'b0;
		palWrite    = 1'b0;
		palAddr     = '0;
		palData     = '0;
		ctrlWrite   = 1'b0;
		ctrlSel     = LatchShadow;
		ctrlValue   = 1'b0;
		pixelIndex  = '0;
		hBlankIn    = 1'b0;
		vBlankIn    = 1'b0;
		videoEnable = 1'b0;
		refBank     = 1'b0;
		refShadow   = 1'b0;
		curEnable   = 1'b0;
		void'($urandom(Seed));

		checkReset();
		checkDecode();
		checkBanks();
		checkShadow();
		checkDisable();
		testName = "blank alignment";
		showPixels(BlankCount);
		// Push the last blank pixels through
		showPixels(3);

		$display("sim passed");
		$finish;
	end

endmodule

// ==== all.f ====
+incdir+tb
verilog/videoPkg.sv
verilog/pixelClockGen.sv
verilog/systemLatch.sv
verilog/paletteRam.sv
verilog/colorDecode.sv
verilog/pixelOutput.sv
verilog/paletteVideoTop.sv
tb/paletteVideoTb.sv

// ==== Makefile ====
# Verilator flow for the palette video path

TOP = paletteVideoTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f all.f \
		--top-module $(TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf obj_dir
